// File: Bender.yml
package:
  name: vga_scanout

sources:
  - files:
      - src/vga_timing_pkg.sv
      - src/pixel_pkg.sv
      - src/pixel_stream_if.sv
      - src/frame_buf.sv
      - src/display_plane.sv
      - src/pixel_fifo.sv
      - src/vga_logic.sv
      - src/top_level.sv
  - target: test
    files:
      - tests/tb_top_level.sv

// File: files.f
src/vga_timing_pkg.sv
src/pixel_pkg.sv
src/pixel_stream_if.sv
src/frame_buf.sv
src/display_plane.sv
src/pixel_fifo.sv
src/vga_logic.sv
src/top_level.sv
tests/tb_top_level.sv

// File: src/display_plane.sv
`default_nettype none

module display_plane import pixel_pkg::*; (
	input  logic             clk_100mhz,
	input  logic             rst_n,
	output fb_addr_t         raddr,
	input  color_idx_t       rdata,
	pixel_stream_if.producer out_stream,
	output logic             ready
);

	// Read goes out this cycle
	logic issue;
	// Memory holds a word for us
	logic rd_pending;
	// FIFO filled at least once
	logic primed;
	// Expanded colour of rdata
	rgb_t color;

	// Room for this read plus both in flight
	assign issue = !out_stream.almost_full;

	////////////////////
	// Raster address walk
	////////////////////

	always_ff @(posedge clk_100mhz) begin
		if (!rst_n) begin
			raddr      <= '0;
			rd_pending <= 1'b0;
		end else begin
			rd_pending <= issue;
			if (issue) begin
				// Last pixel of the frame wraps to top-left
				if (raddr == fb_addr_t'(FB_WORDS - 1)) begin
					raddr <= '0;
				end else begin
					raddr <= raddr + 1'b1;
				end
			end
		end
	end

	////////////////////
	// Palette and push
	////////////////////

	always_comb begin
		case (rdata)
			3'd0:    color = BLACK;
			3'd1:    color = GREEN;
			3'd2:    color = BLUE;
			3'd3:    color = RED;
			3'd4:    color = TEAL;
			3'd5:    color = GRAY;
			3'd6:    color = WHITE;
			3'd7:    color = GWHITE;
			default: color = BLACK;
		endcase
	end

	// Push strobe follows the returned read by one cycle
	always_ff @(posedge clk_100mhz) begin
		if (!rst_n) begin
			out_stream.push <= 1'b0;
		end else begin
			out_stream.push <= rd_pending;
		end
	end

	// Colour rides along with the strobe
	always_ff @(posedge clk_100mhz) begin
		out_stream.push_data <= color;
	end

	// Sticky once the FIFO first reports almost full
	always_ff @(posedge clk_100mhz) begin
		if (!rst_n) begin
			primed <= 1'b0;
		end else begin
			primed <= primed | out_stream.almost_full;
		end
	end

	assign ready = primed | out_stream.almost_full;

endmodule

`default_nettype wire

// File: src/frame_buf.sv
`default_nettype none

module frame_buf import pixel_pkg::*; (
	input  logic       clk_100mhz,
	input  logic       we,
	input  fb_addr_t   waddr,
	input  color_idx_t wdata,
	input  fb_addr_t   raddr,
	output color_idx_t rdata
);

	// One colour index per visible pixel, raster order
	color_idx_t mem [FB_WORDS];

	// Blank screen until the host writes something
	initial begin
		for (int i = 0; i < FB_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	////////////////////
	// Host write port
	////////////////////

	always_ff @(posedge clk_100mhz) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	////////////////////
	// Display read port
	////////////////////

	// Registered output, one cycle latency
	// Same-cycle collision returns the old word
	always_ff @(posedge clk_100mhz) begin
		rdata <= mem[raddr];
	end

	// Host addresses past the last pixel would alias nowhere
	a_waddr_range: assert property (@(posedge clk_100mhz)
		we |-> (waddr < FB_WORDS))
		else $error("frame buffer write beyond last pixel");

endmodule

`default_nettype wire

// File: src/pixel_fifo.sv
`default_nettype none

module pixel_fifo import pixel_pkg::*; #(
	parameter type payload_t = rgb_t
) (
	input logic            clk_100mhz,
	input logic            rst_n,
	pixel_stream_if.buffer io
);

	// Circular storage
	payload_t mem [FIFO_DEPTH];

	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	// One extra bit so 16 fits
	logic [FIFO_AW:0]   count;
	logic               full;

	////////////////////
	// Status flags
	////////////////////

	assign full           = (count == FIFO_DEPTH);
	assign io.empty       = (count == '0);
	// Two free slots left, room for what is still in flight
	assign io.almost_full = (count >= FIFO_DEPTH - FIFO_AF_FREE);

	// Head entry shows without a read strobe
	assign io.pop_data = mem[rd_ptr];

	////////////////////
	// Storage and pointers
	////////////////////

	always_ff @(posedge clk_100mhz) begin
		if (io.push) begin
			mem[wr_ptr] <= io.push_data;
		end
	end

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk_100mhz) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (io.push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (io.pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Push and pop together leave the level alone
			case ({io.push, io.pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
		io.push |-> !full)
		else $error("pixel FIFO overflow");

	a_no_underflow: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
		io.pop |-> !io.empty)
		else $error("pixel FIFO underflow");

endmodule

`default_nettype wire

// File: src/pixel_pkg.sv
`default_nettype none

package pixel_pkg;

	// Palette index as stored in the frame buffer
	typedef logic [2:0] color_idx_t;

	// One byte per channel, red in the top byte
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	////////////////////
	// Fixed palette, index 0 to 7
	localparam rgb_t BLACK  = 24'h000000;
	localparam rgb_t GREEN  = 24'h00FF00;
	localparam rgb_t BLUE   = 24'h0000FF;
	localparam rgb_t RED    = 24'hFF0000;
	localparam rgb_t TEAL   = 24'h66FFFF;
	localparam rgb_t GRAY   = 24'hD3D3D3;
	localparam rgb_t WHITE  = 24'hFFFFFF;
	localparam rgb_t GWHITE = 24'hCCFF99;

	////////////////////
	// Frame buffer, one index per visible pixel
	localparam int FB_WIDTH  = 640;
	localparam int FB_HEIGHT = 480;
	localparam int FB_WORDS  = FB_WIDTH * FB_HEIGHT;
	// 19 bits covers 307200 words
	typedef logic [18:0] fb_addr_t;

	// Pixel FIFO sizing, depth must stay a power of two
	localparam int FIFO_DEPTH   = 16;
	localparam int FIFO_AW      = $clog2(FIFO_DEPTH);
	// Free slots at which almost_full rises
	localparam int FIFO_AF_FREE = 2;

endpackage

`default_nettype wire

// File: src/pixel_stream_if.sv
`default_nettype none

interface pixel_stream_if import pixel_pkg::*; #(
	parameter type payload_t = rgb_t
) ();

	// Write side, from the display plane
	payload_t push_data;
	logic     push;
	// High with two or fewer free slots
	logic     almost_full;

	// Read side, toward the VGA timing block
	payload_t pop_data;
	logic     pop;
	logic     empty;

	// Display plane
	modport producer (output push_data, output push, input almost_full);

	// FIFO itself
	modport buffer (
		input push_data, input push, output almost_full,
		output pop_data, input pop, output empty
	);

	// VGA timing block
	modport consumer (output pop, input pop_data, input empty);

endinterface

`default_nettype wire

// File: src/top_level.sv
`default_nettype none

module top_level import pixel_pkg::*; (
	input  logic       clk_100mhz,
	input  logic       rst_n,
	// Host write port into the frame buffer
	input  fb_addr_t   waddr,
	input  color_idx_t wdata,
	input  logic       we,
	output logic       ready,
	// VGA connector side
	output logic       vgaclk,
	output logic       blank,
	output logic       comp_sync,
	output logic       hsync,
	output logic       vsync,
	output logic [7:0] pixel_r,
	output logic [7:0] pixel_g,
	output logic [7:0] pixel_b
);

	// Display plane to frame buffer
	fb_addr_t   raddr;
	color_idx_t rdata;
	// Registered colour from the timing block
	rgb_t       rgb;

	// Producer, FIFO and consumer share one stream
	pixel_stream_if #(.payload_t(rgb_t)) stream ();

	frame_buf u_frame_buf (
		.clk_100mhz (clk_100mhz),
		.we         (we),
		.waddr      (waddr),
		.wdata      (wdata),
		.raddr      (raddr),
		.rdata      (rdata)
	);

	display_plane u_display_plane (
		.clk_100mhz (clk_100mhz),
		.rst_n      (rst_n),
		.raddr      (raddr),
		.rdata      (rdata),
		.out_stream (stream.producer),
		.ready      (ready)
	);

	pixel_fifo #(.payload_t(rgb_t)) u_pixel_fifo (
		.clk_100mhz (clk_100mhz),
		.rst_n      (rst_n),
		.io         (stream.buffer)
	);

	vga_logic u_vga_logic (
		.clk_100mhz (clk_100mhz),
		.rst_n      (rst_n),
		.in_stream  (stream.consumer),
		.vgaclk     (vgaclk),
		.blank      (blank),
		.hsync      (hsync),
		.vsync      (vsync),
		.comp_sync  (comp_sync),
		.rgb        (rgb)
	);

	// Split the packed colour onto the DAC pins
	assign pixel_r = rgb.r;
	assign pixel_g = rgb.g;
	assign pixel_b = rgb.b;

endmodule

`default_nettype wire

// File: src/vga_logic.sv
`default_nettype none

module vga_logic import vga_timing_pkg::*, pixel_pkg::*; (
	input  logic             clk_100mhz,
	input  logic             rst_n,
	pixel_stream_if.consumer in_stream,
	output logic             vgaclk,
	output logic             blank,
	output logic             hsync,
	output logic             vsync,
	output logic             comp_sync,
	output rgb_t             rgb
);

	logic [DIV_W-1:0] div;
	logic [DIV_W-1:0] div_next;
	logic             pix_en;
	h_count_t         h_cnt;
	v_count_t         v_cnt;
	logic             active;
	logic             h_sync_on;
	logic             v_sync_on;
	// FIFO has delivered at least once
	logic             seen_data;

	////////////////////
	// Pixel rate
	////////////////////

	// Enable on the last of every four cycles
	assign pix_en   = (div == PIX_DIV - 1);
	assign div_next = pix_en ? '0 : div + 1'b1;

	// vgaclk low for two cycles after each enable, then high for two
	always_ff @(posedge clk_100mhz) begin
		if (!rst_n) begin
			div    <= '0;
			vgaclk <= 1'b0;
		end else begin
			div    <= div_next;
			vgaclk <= (div_next >= PIX_DIV / 2);
		end
	end

	////////////////////
	// Raster position
	////////////////////

	always_ff @(posedge clk_100mhz) begin
		if (!rst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (pix_en) begin
			if (h_cnt == H_TOTAL - 1) begin
				h_cnt <= '0;
				// End of frame back to line 0
				if (v_cnt == V_TOTAL - 1) begin
					v_cnt <= '0;
				end else begin
					v_cnt <= v_cnt + 1'b1;
				end
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// Decode of the current position
	assign active    = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
	assign h_sync_on = (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END);
	assign v_sync_on = (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END);

	// One pixel consumed per visible position
	assign in_stream.pop = pix_en && active && !in_stream.empty;

	////////////////////
	// Video outputs
	////////////////////

	// Syncs idle high, RGB black outside the picture
	always_ff @(posedge clk_100mhz) begin
		if (!rst_n) begin
			blank     <= 1'b1;
			hsync     <= 1'b1;
			vsync     <= 1'b1;
			comp_sync <= 1'b1;
			rgb       <= '0;
		end else if (pix_en) begin
			blank     <= !active;
			hsync     <= !h_sync_on;
			vsync     <= !v_sync_on;
			comp_sync <= !(h_sync_on || v_sync_on);
			rgb       <= in_stream.pop ? in_stream.pop_data : '0;
		end
	end

	always_ff @(posedge clk_100mhz) begin
		if (!rst_n) begin
			seen_data <= 1'b0;
		end else begin
			seen_data <= seen_data | !in_stream.empty;
		end
	end

	// Once streaming, the display plane must keep ahead of the raster
	a_no_underrun: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
		(seen_data && pix_en && active) |-> !in_stream.empty)
		else $error("pixel underrun in active area");

endmodule

`default_nettype wire

// File: src/vga_timing_pkg.sv
`default_nettype none

package vga_timing_pkg;

	////////////////////
	// Horizontal line
	////////////////////

	// Pixels per line, in scan order
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT  = 16;
	localparam int H_SYNC   = 96;
	localparam int H_BACK   = 48;
	localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

	// hsync low from 656 up to 751
	localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
	localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;

	////////////////////
	// Vertical frame
	////////////////////

	// Lines per frame, same order
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT  = 10;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 33;
	localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	// vsync low on lines 490 and 491
	localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
	localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

	// 100 MHz down to the 25 MHz pixel rate
	localparam int PIX_DIV = 4;
	localparam int DIV_W   = $clog2(PIX_DIV);

	// Counter types, wide enough for 800 and 525
	typedef logic [9:0] h_count_t;
	typedef logic [9:0] v_count_t;

endpackage

`default_nettype wire

// File: tests/tb_top_level.sv
`default_nettype none

module tb_top_level import vga_timing_pkg::*, pixel_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// Rows 2 to 4 of the frame buffer get random indices
	localparam int WR_FIRST     = 2 * FB_WIDTH;
	localparam int WR_LAST      = 5 * FB_WIDTH - 1;
	localparam int FRAME_PIXELS = H_TOTAL * V_TOTAL;
	// Clock cycles allowed per wait
	localparam int RISE_LIMIT   = 4 * PIX_DIV;
	localparam int READY_LIMIT  = 200;

	logic       clk_100mhz;
	logic       rst_n;
	fb_addr_t   waddr;
	color_idx_t wdata;
	logic       we;
	logic       ready;
	logic       vgaclk;
	logic       blank;
	logic       comp_sync;
	logic       hsync;
	logic       vsync;
	logic [7:0] pixel_r;
	logic [7:0] pixel_g;
	logic [7:0] pixel_b;

	integer     seed;
	int         errors;
	logic       vgaclk_prev;
	logic       ready_seen;
	// Raster position of the sample under check
	// Both are -1 outside the frame
	int         cur_x;
	int         cur_y;
	// Reference copy of the frame buffer
	color_idx_t model [FB_WORDS];
	rgb_t       palette [8];

	top_level UUT (
		.clk_100mhz (clk_100mhz),
		.rst_n      (rst_n),
		.waddr      (waddr),
		.wdata      (wdata),
		.we         (we),
		.ready      (ready),
		.vgaclk     (vgaclk),
		.blank      (blank),
		.comp_sync  (comp_sync),
		.hsync      (hsync),
		.vsync      (vsync),
		.pixel_r    (pixel_r),
		.pixel_g    (pixel_g),
		.pixel_b    (pixel_b)
	);

	// 100 MHz system clock
	initial begin
		clk_100mhz = 1'b0;
		forever begin
			#5 clk_100mhz = ~clk_100mhz;
		end
	end

	////////////////////
	// Reporting
	////////////////////

	task automatic compare_value(input logic [23:0] actual, input logic [23:0] expected,
			input string what);
		if (actual !== expected) begin
			errors++;
			if (cur_y >= 0) begin
				$display("Fail at %0t: %s at column %0d row %0d, got %h, expected %h",
					$time, what, cur_x, cur_y, actual, expected);
			end else begin
				$display("Fail at %0t: %s, got %h, expected %h", $time, what, actual, expected);
			end
			$display("FAIL: see errors above");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t: %s", $time, what);
		$display("FAIL: see errors above");
		$fatal(1, "stopped on timeout");
	endtask

	////////////////////
	// Waits
	////////////////////

	// Outputs are sampled at the falling clock edge after vgaclk rises
	// Between two rises vgaclk spans four clocks and is low for two of them
	task automatic wait_vgaclk_rise(input logic check_shape);
		int   n;
		int   low_n;
		logic found;
		n     = 0;
		low_n = 0;
		found = 1'b0;
		while (!found && n < RISE_LIMIT) begin
			@(negedge clk_100mhz);
			found       = vgaclk && !vgaclk_prev;
			vgaclk_prev = vgaclk;
			if (!vgaclk) begin
				low_n++;
			end
			n++;
		end
		if (!found) begin
			report_timeout("vgaclk did not rise within four pixel periods");
		end
		if (check_shape) begin
			compare_value(n, PIX_DIV, "vgaclk period in clock cycles");
			compare_value(low_n, PIX_DIV / 2, "vgaclk low clock cycles");
		end
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (!ready && n < READY_LIMIT) begin
			@(negedge clk_100mhz);
			n++;
		end
		if (!ready) begin
			report_timeout("ready never rose after reset");
		end
		ready_seen = 1'b1;
	endtask

	////////////////////
	// Stimulus
	////////////////////

	// One write per cycle over every address of rows 2 to 4
	task automatic write_rows();
		color_idx_t idx;
		for (int a = WR_FIRST; a <= WR_LAST; a++) begin
			@(posedge clk_100mhz);
			#1;
			idx      = color_idx_t'($random(seed));
			waddr    = fb_addr_t'(a);
			wdata    = idx;
			we       = 1'b1;
			model[a] = idx;
		end
		@(posedge clk_100mhz);
		#1;
		we = 1'b0;
	endtask

	////////////////////
	// Output checks
	////////////////////

	// Syncs idle high and the picture blanked to black
	task automatic expect_idle_outputs();
		compare_value(blank, 1'b1, "blank after reset");
		compare_value(hsync, 1'b1, "hsync after reset");
		compare_value(vsync, 1'b1, "vsync after reset");
		compare_value(comp_sync, 1'b1, "comp_sync after reset");
		compare_value({pixel_r, pixel_g, pixel_b}, 24'h0, "RGB after reset");
	endtask

	task automatic check_pixel(input int p);
		int   x;
		int   y;
		logic act;
		logic hs_n;
		logic vs_n;
		rgb_t exp_rgb;
		x     = p % H_TOTAL;
		y     = p / H_TOTAL;
		cur_x = x;
		cur_y = y;
		act   = (x < H_ACTIVE) && (y < V_ACTIVE);
		// Sync pulses follow the front porch
		hs_n  = !((x >= H_ACTIVE + H_FRONT) && (x < H_ACTIVE + H_FRONT + H_SYNC));
		vs_n  = !((y >= V_ACTIVE + V_FRONT) && (y < V_ACTIVE + V_FRONT + V_SYNC));
		if (act) begin
			exp_rgb = palette[model[y * FB_WIDTH + x]];
		end else begin
			exp_rgb = '0;
		end
		compare_value(blank, !act, "blank");
		compare_value(hsync, hs_n, "hsync");
		compare_value(vsync, vs_n, "vsync");
		compare_value(comp_sync, hs_n && vs_n, "comp_sync");
		compare_value({pixel_r, pixel_g, pixel_b}, exp_rgb, "pixel colour");
		if (ready_seen) begin
			compare_value(ready, 1'b1, "ready dropped");
		end
	endtask

	// Frame 0 pixel by pixel with per-line and per-frame counts
	task automatic scan_frame();
		int x;
		int line_blank_low;
		int line_hsync_low;
		int first_hsync_low;
		int vsync_lines;
		int blank_lines;
		line_blank_low  = 0;
		line_hsync_low  = 0;
		first_hsync_low = -1;
		vsync_lines     = 0;
		blank_lines     = 0;
		// First rise comes before the first pixel enable
		wait_vgaclk_rise(1'b0);
		expect_idle_outputs();
		for (int p = 0; p < FRAME_PIXELS; p++) begin
			wait_vgaclk_rise(1'b1);
			check_pixel(p);
			x = p % H_TOTAL;
			if (x == 0) begin
				line_blank_low  = 0;
				line_hsync_low  = 0;
				first_hsync_low = -1;
			end
			if (!blank) begin
				line_blank_low++;
			end
			if (!hsync) begin
				if (first_hsync_low < 0) begin
					first_hsync_low = x;
				end
				line_hsync_low++;
			end
			// End of line totals
			if (x == H_TOTAL - 1) begin
				compare_value(line_blank_low, (cur_y < V_ACTIVE) ? H_ACTIVE : 0,
					"visible pixels in line");
				compare_value(line_hsync_low, H_SYNC, "hsync low pixels in line");
				compare_value(first_hsync_low, H_ACTIVE + H_FRONT, "hsync start column");
				if (line_blank_low == 0) begin
					blank_lines++;
				end
				if (!vsync) begin
					vsync_lines++;
				end
			end
		end
		compare_value(vsync_lines, V_SYNC, "lines with vsync low");
		compare_value(blank_lines, V_TOTAL - V_ACTIVE, "fully blanked lines");
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		rst_n       = 1'b0;
		we          = 1'b0;
		waddr       = '0;
		wdata       = '0;
		seed        = 92480;
		errors      = 0;
		ready_seen  = 1'b0;
		vgaclk_prev = 1'b0;
		cur_x       = -1;
		cur_y       = -1;
		for (int i = 0; i < FB_WORDS; i++) begin
			model[i] = '0;
		end
		// Palette for indices 0 to 7
		palette[0] = BLACK;
		palette[1] = GREEN;
		palette[2] = BLUE;
		palette[3] = RED;
		palette[4] = TEAL;
		palette[5] = GRAY;
		palette[6] = WHITE;
		palette[7] = GWHITE;

		repeat (3) @(posedge clk_100mhz);
		#1;
		rst_n = 1'b1;

		@(negedge clk_100mhz);
		vgaclk_prev = vgaclk;
		expect_idle_outputs();

		// Host writes, priming and scan-out all overlap
		fork
			write_rows();
			wait_ready();
			scan_frame();
		join

		cur_x = -1;
		cur_y = -1;
		compare_value(ready, 1'b1, "ready at end of frame");

		if (errors == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			$display("FAIL: see errors above");
			$fatal(1, "errors were reported");
		end
	end

endmodule

`default_nettype wire
